// File: source/mgmt_io_cfg.svh
/*
 * Management I/O configuration
 * Pad count, pad map, register addresses and the flash pass-through command
 */
`ifndef MGMT_IO_CFG_SVH
`define MGMT_IO_CFG_SVH

// Management pads, 16 or more
`define MGMT_IO_PADS 16

// Housekeeping pins
`define PAD_JTAG 0
`define PAD_SDO 1
`define PAD_SDI 2
`define PAD_CSB 3
`define PAD_SCK 4

// User flash pins
`define PAD_UFL_CSB 8
`define PAD_UFL_SCK 9
`define PAD_UFL_IO0 10
`define PAD_UFL_IO1 11

// Housekeeping register map
`define HK_ADDR_MASKREV 0
`define HK_ADDR_IRQ 1
`define HK_ADDR_RESET 2

// Command byte that opens flash pass-through
`define HK_CMD_PASSTHRU 8'hC4

// GPIO register map and control bits
`define BUS_ADDR_DATA 0
`define BUS_ADDR_OEB 1
`define BUS_ADDR_CTRL 2
`define CTRL_SDO_OVR 0
`define CTRL_JTAG_OVR 1
`define CTRL_HK_CONNECT 2

`endif

// File: source/mgmt_io_pkg.sv
/*
 * Management I/O types
 * Pad vectors, SPI bytes, bus words and the housekeeping FSM states
 */
`include "mgmt_io_cfg.svh"

package mgmt_io_pkg;

	// One bit per management pad
	typedef logic [`MGMT_IO_PADS-1:0] io_vec_t;

	// One housekeeping SPI byte
	typedef logic [7:0] hk_byte_t;

	// SoC bus data word
	typedef logic [31:0] bus_word_t;

	// GPIO register index
	typedef logic [1:0] bus_addr_t;

	// Housekeeping slave FSM
	typedef enum logic [1:0] {
		HK_IDLE,
		HK_CMD,
		HK_DATA,
		HK_PASS
	} hk_state_e;

endpackage

// File: source/hk_spi_slave.sv
/*
 * Housekeeping SPI slave
 * Oversamples the SPI pins, decodes command/data byte pairs into the
 * housekeeping registers and relays a user flash pass-through
 */
`include "mgmt_io_cfg.svh"

module hk_spi_slave import mgmt_io_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_n_i,
	// SPI pins, after the pad mux
	input  logic     csb_i,
	input  logic     sck_i,
	input  logic     sdi_i,
	// Flash data, sent back on SDO in pass-through
	input  logic     ufl_io1_i,
	input  hk_byte_t mask_rev_i,
	output logic     sdo_o,
	output logic     sdo_enb_o,
	output logic     pass_thru_o,
	output logic     ufl_csb_o,
	output logic     ufl_sck_o,
	output logic     ufl_sdi_o,
	output logic     irq_o,
	output logic     ext_reset_o
);

	// Two-flop synchronizers with bit 1 as the synchronized value
	logic [1:0] csb_sync_q;
	logic [1:0] sck_sync_q;
	logic [1:0] sdi_sync_q;
	logic       csb_s;
	logic       sck_s;
	logic       sdi_s;
	logic       sck_prev_q;
	logic       sck_rise;
	logic       sck_fall;

	hk_state_e  state_q;
	logic [2:0] bit_cnt_q;
	hk_byte_t   shift_q;
	hk_byte_t   rx_byte;
	hk_byte_t   rd_data;
	hk_byte_t   sdo_shift_q;
	logic [6:0] addr_q;
	logic       wr_q;
	logic       cmd_done;
	logic       data_done;
	logic       irq_q;
	logic       ext_reset_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			// CSB idles high so nothing is selected out of reset
			csb_sync_q <= 2'b11;
			sck_sync_q <= 2'b00;
			sdi_sync_q <= 2'b00;
			sck_prev_q <= 1'b0;
		end else begin
			csb_sync_q <= {csb_sync_q[0], csb_i};
			sck_sync_q <= {sck_sync_q[0], sck_i};
			sdi_sync_q <= {sdi_sync_q[0], sdi_i};
			sck_prev_q <= sck_s;
		end
	end

	assign csb_s = csb_sync_q[1];
	assign sck_s = sck_sync_q[1];
	assign sdi_s = sdi_sync_q[1];

	// Edges seen one cycle after the synchronized level
	assign sck_rise = sck_s && !sck_prev_q;
	assign sck_fall = !sck_s && sck_prev_q;

	// Byte as it stands once the current bit is shifted in MSB first
	assign rx_byte = {shift_q[6:0], sdi_s};

	// Eighth rise of each byte
	assign cmd_done  = !csb_s && state_q == HK_CMD && sck_rise && bit_cnt_q == 3'd7;
	assign data_done = !csb_s && state_q == HK_DATA && sck_rise && bit_cnt_q == 3'd7;

	// Register read mux addressed by the command byte just received
	always_comb begin
		case (rx_byte[6:0])
			7'(`HK_ADDR_MASKREV): rd_data = mask_rev_i;
			7'(`HK_ADDR_IRQ):     rd_data = {7'b0, irq_q};
			7'(`HK_ADDR_RESET):   rd_data = {7'b0, ext_reset_q};
			default:              rd_data = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q     <= HK_IDLE;
			bit_cnt_q   <= '0;
			irq_q       <= 1'b0;
			ext_reset_q <= 1'b0;
		end else if (csb_s) begin
			// Deselect aborts whatever was in progress
			state_q   <= HK_IDLE;
			bit_cnt_q <= '0;
		end else begin
			case (state_q)
				HK_IDLE: begin
					state_q   <= HK_CMD;
					bit_cnt_q <= '0;
				end
				HK_CMD: begin
					if (sck_rise) begin
						// Counter wraps to 0 at the end of the byte
						bit_cnt_q <= bit_cnt_q + 3'd1;
					end
					if (cmd_done && rx_byte == `HK_CMD_PASSTHRU) begin
						state_q <= HK_PASS;
					end else if (cmd_done) begin
						state_q <= HK_DATA;
					end
				end
				HK_DATA: begin
					if (sck_rise) begin
						bit_cnt_q <= bit_cnt_q + 3'd1;
					end
					if (data_done) begin
						// Ready for another command in the same frame
						state_q <= HK_CMD;
					end
					if (data_done && wr_q && addr_q == 7'(`HK_ADDR_IRQ)) begin
						irq_q <= rx_byte[0];
					end
					if (data_done && wr_q && addr_q == 7'(`HK_ADDR_RESET)) begin
						ext_reset_q <= rx_byte[0];
					end
				end
				default: begin
					// Pass-through holds until CSB rises
					state_q <= HK_PASS;
				end
			endcase
		end
	end

	// Shift and command capture
	always_ff @(posedge clk_i) begin
		if (sck_rise) begin
			shift_q <= rx_byte;
		end
		if (cmd_done) begin
			wr_q        <= rx_byte[7];
			addr_q      <= rx_byte[6:0];
			sdo_shift_q <= rd_data;
		end else if (state_q == HK_DATA && sck_fall && bit_cnt_q != 3'd0) begin
			// MSB is already out so the fall right after the command is skipped
			sdo_shift_q <= {sdo_shift_q[6:0], 1'b0};
		end
	end

	// SDO driven for read data or the flash reply
	assign sdo_enb_o = !((state_q == HK_DATA && !wr_q) || state_q == HK_PASS);

	always_comb begin
		if (state_q == HK_PASS) begin
			sdo_o = ufl_io1_i;
		end else if (!sdo_enb_o) begin
			sdo_o = sdo_shift_q[7];
		end else begin
			sdo_o = 1'b0;
		end
	end

	assign pass_thru_o = state_q == HK_PASS;

	// Flash pins idle when not relaying
	assign ufl_csb_o = pass_thru_o ? csb_s : 1'b1;
	assign ufl_sck_o = pass_thru_o && sck_s;
	assign ufl_sdi_o = pass_thru_o && sdi_s;

	assign irq_o       = irq_q;
	assign ext_reset_o = ext_reset_q;

	// Pass-through drops one cycle after deselect at the latest
	a_pass_ends: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		csb_s && $past(csb_s) |-> !pass_thru_o);

	// Deselect leaves the FSM idle with SDO released
	a_idle_enb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		csb_s && $past(csb_s) |-> sdo_enb_o);

endmodule

// File: source/gpio_ctrl_regs.sv
/*
 * GPIO control registers
 * Pad data, output enables and override bits on a valid/ready bus
 */
`include "mgmt_io_cfg.svh"

module gpio_ctrl_regs import mgmt_io_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	// Request channel
	input  logic      bus_valid_i,
	output logic      bus_ready_o,
	input  logic      bus_we_i,
	input  bus_addr_t bus_addr_i,
	input  bus_word_t bus_wdata_i,
	// Response channel
	output logic      bus_rsp_valid_o,
	input  logic      bus_rsp_ready_i,
	output bus_word_t bus_rdata_o,
	// To the pad mux
	output io_vec_t   soc_out_o,
	output io_vec_t   soc_oeb_o,
	output logic      sdo_ovr_o,
	output logic      jtag_ovr_o,
	output logic      hk_connect_o
);

	localparam int CTRL_W = `CTRL_HK_CONNECT + 1;

	io_vec_t           data_q;
	io_vec_t           data_d;
	io_vec_t           oeb_q;
	io_vec_t           oeb_d;
	logic [CTRL_W-1:0] ctrl_q;
	logic [CTRL_W-1:0] ctrl_d;
	logic              rsp_valid_q;
	bus_word_t         rdata_q;
	bus_word_t         rdata_d;
	logic              req_acc;

	// Stall only while a response is stuck
	assign bus_ready_o = !rsp_valid_q || bus_rsp_ready_i;
	assign req_acc     = bus_valid_i && bus_ready_o;

	// Register update on an accepted write
	always_comb begin
		data_d = data_q;
		oeb_d  = oeb_q;
		ctrl_d = ctrl_q;
		if (req_acc && bus_we_i) begin
			case (bus_addr_i)
				2'(`BUS_ADDR_DATA): data_d = io_vec_t'(bus_wdata_i);
				2'(`BUS_ADDR_OEB):  oeb_d  = io_vec_t'(bus_wdata_i);
				2'(`BUS_ADDR_CTRL): ctrl_d = bus_wdata_i[CTRL_W-1:0];
				default: begin
					// Unmapped slot, write dropped
				end
			endcase
		end
	end

	// Response data from the updated values, so a write echoes the new value
	always_comb begin
		case (bus_addr_i)
			2'(`BUS_ADDR_DATA): rdata_d = bus_word_t'(data_d);
			2'(`BUS_ADDR_OEB):  rdata_d = bus_word_t'(oeb_d);
			2'(`BUS_ADDR_CTRL): rdata_d = bus_word_t'(ctrl_d);
			default:            rdata_d = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			data_q      <= '0;
			// All pads start as inputs
			oeb_q       <= '1;
			ctrl_q      <= '0;
			rsp_valid_q <= 1'b0;
		end else begin
			data_q <= data_d;
			oeb_q  <= oeb_d;
			ctrl_q <= ctrl_d;
			if (req_acc) begin
				rsp_valid_q <= 1'b1;
			end else if (bus_rsp_ready_i) begin
				rsp_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_acc) begin
			rdata_q <= rdata_d;
		end
	end

	assign bus_rsp_valid_o = rsp_valid_q;
	assign bus_rdata_o     = rdata_q;

	assign soc_out_o    = data_q;
	assign soc_oeb_o    = oeb_q;
	assign sdo_ovr_o    = ctrl_q[`CTRL_SDO_OVR];
	assign jtag_ovr_o   = ctrl_q[`CTRL_JTAG_OVR];
	assign hk_connect_o = ctrl_q[`CTRL_HK_CONNECT];

	// Held response keeps its data
	a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		bus_rsp_valid_o && !bus_rsp_ready_i |=> bus_rsp_valid_o && $stable(bus_rdata_o));

endmodule

// File: source/pad_io_mux.sv
/*
 * Management pad mux
 * Merges SoC pad data with housekeeping SDO, JTAG and flash pass-through,
 * and picks the housekeeping SPI inputs
 */
`include "mgmt_io_cfg.svh"

module pad_io_mux import mgmt_io_pkg::*; (
	input  io_vec_t pad_in_i,
	input  io_vec_t soc_out_i,
	input  io_vec_t soc_oeb_i,
	input  logic    sdo_ovr_i,
	input  logic    jtag_ovr_i,
	input  logic    hk_connect_i,
	// From the housekeeping slave
	input  logic    hk_sdo_i,
	input  logic    hk_sdo_enb_i,
	input  logic    pass_thru_i,
	input  logic    ufl_csb_i,
	input  logic    ufl_sck_i,
	input  logic    ufl_sdi_i,
	output io_vec_t pad_out_o,
	output io_vec_t pad_oeb_o,
	// To the housekeeping slave
	output logic    hk_csb_o,
	output logic    hk_sck_o,
	output logic    hk_sdi_o,
	output logic    ufl_io1_o
);

	always_comb begin
		// SoC owns every pad unless a rule below takes it
		pad_out_o = soc_out_i;
		pad_oeb_o = soc_oeb_i;

		// JTAG not implemented, output low unless the SoC overrides
		pad_out_o[`PAD_JTAG] = jtag_ovr_i ? soc_out_i[`PAD_JTAG] : 1'b0;

		// SDO from housekeeping unless overridden
		pad_out_o[`PAD_SDO] = sdo_ovr_i ? soc_out_i[`PAD_SDO] : hk_sdo_i;
		pad_oeb_o[`PAD_SDO] = sdo_ovr_i ? soc_oeb_i[`PAD_SDO] : hk_sdo_enb_i;

		// User flash pins relayed during pass-through
		if (pass_thru_i) begin
			pad_out_o[`PAD_UFL_CSB] = ufl_csb_i;
			pad_out_o[`PAD_UFL_SCK] = ufl_sck_i;
			pad_out_o[`PAD_UFL_IO0] = ufl_sdi_i;
		end
	end

	// hk_connect loops the SoC outputs back into the slave
	assign hk_csb_o = hk_connect_i ? soc_out_i[`PAD_CSB] : pad_in_i[`PAD_CSB];
	assign hk_sck_o = hk_connect_i ? soc_out_i[`PAD_SCK] : pad_in_i[`PAD_SCK];
	assign hk_sdi_o = hk_connect_i ? soc_out_i[`PAD_SDI] : pad_in_i[`PAD_SDI];

	// Flash reply
	assign ufl_io1_o = pad_in_i[`PAD_UFL_IO1];

endmodule

// File: source/mgmt_io_top.sv
/*
 * Management I/O top
 * Housekeeping SPI slave and GPIO registers joined through the pad mux
 */
`include "mgmt_io_cfg.svh"

module mgmt_io_top import mgmt_io_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	// Pads
	input  io_vec_t   pad_in_i,
	output io_vec_t   pad_out_o,
	output io_vec_t   pad_oeb_o,
	// Housekeeping
	input  hk_byte_t  mask_rev_i,
	output logic      irq_o,
	output logic      ext_reset_o,
	// SoC bus
	input  logic      bus_valid_i,
	output logic      bus_ready_o,
	input  logic      bus_we_i,
	input  bus_addr_t bus_addr_i,
	input  bus_word_t bus_wdata_i,
	output logic      bus_rsp_valid_o,
	input  logic      bus_rsp_ready_i,
	output bus_word_t bus_rdata_o
);

	// GPIO registers to mux
	io_vec_t soc_out;
	io_vec_t soc_oeb;
	logic    sdo_ovr;
	logic    jtag_ovr;
	logic    hk_connect;

	// Slave to mux
	logic    hk_sdo;
	logic    hk_sdo_enb;
	logic    pass_thru;
	logic    ufl_csb;
	logic    ufl_sck;
	logic    ufl_sdi;

	// Mux to slave
	logic    hk_csb;
	logic    hk_sck;
	logic    hk_sdi;
	logic    ufl_io1;

	hk_spi_slave u_hk_spi (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.csb_i       (hk_csb),
		.sck_i       (hk_sck),
		.sdi_i       (hk_sdi),
		.ufl_io1_i   (ufl_io1),
		.mask_rev_i  (mask_rev_i),
		.sdo_o       (hk_sdo),
		.sdo_enb_o   (hk_sdo_enb),
		.pass_thru_o (pass_thru),
		.ufl_csb_o   (ufl_csb),
		.ufl_sck_o   (ufl_sck),
		.ufl_sdi_o   (ufl_sdi),
		.irq_o       (irq_o),
		.ext_reset_o (ext_reset_o)
	);

	gpio_ctrl_regs u_gpio_regs (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.bus_valid_i     (bus_valid_i),
		.bus_ready_o     (bus_ready_o),
		.bus_we_i        (bus_we_i),
		.bus_addr_i      (bus_addr_i),
		.bus_wdata_i     (bus_wdata_i),
		.bus_rsp_valid_o (bus_rsp_valid_o),
		.bus_rsp_ready_i (bus_rsp_ready_i),
		.bus_rdata_o     (bus_rdata_o),
		.soc_out_o       (soc_out),
		.soc_oeb_o       (soc_oeb),
		.sdo_ovr_o       (sdo_ovr),
		.jtag_ovr_o      (jtag_ovr),
		.hk_connect_o    (hk_connect)
	);

	pad_io_mux u_pad_mux (
		.pad_in_i     (pad_in_i),
		.soc_out_i    (soc_out),
		.soc_oeb_i    (soc_oeb),
		.sdo_ovr_i    (sdo_ovr),
		.jtag_ovr_i   (jtag_ovr),
		.hk_connect_i (hk_connect),
		.hk_sdo_i     (hk_sdo),
		.hk_sdo_enb_i (hk_sdo_enb),
		.pass_thru_i  (pass_thru),
		.ufl_csb_i    (ufl_csb),
		.ufl_sck_i    (ufl_sck),
		.ufl_sdi_i    (ufl_sdi),
		.pad_out_o    (pad_out_o),
		.pad_oeb_o    (pad_oeb_o),
		.hk_csb_o     (hk_csb),
		.hk_sck_o     (hk_sck),
		.hk_sdi_o     (hk_sdi),
		.ufl_io1_o    (ufl_io1)
	);

endmodule

// File: verif/mgmt_io_tb.sv
/*
 * Management I/O testbench
 * Bus driver with response back-pressure, SPI bit-banger on the pads,
 * pad reference model and a per-cycle pad checker
 */
`include "mgmt_io_cfg.svh"

module mgmt_io_tb import mgmt_io_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	// SCK half period in clk cycles
	localparam int HALF = 5;
	localparam int N_RAND = 60;
	localparam int N_SPI = 12;
	localparam int N_BUS = N_RAND + 60;
	localparam int TIMEOUT = N_SPI * 16 * 10 + N_BUS * 20 + 2000;

	logic      clk;
	logic      rst_n;
	io_vec_t   pad_in;
	io_vec_t   pad_out;
	io_vec_t   pad_oeb;
	hk_byte_t  mask_rev;
	logic      irq;
	logic      ext_reset;
	logic      bus_valid;
	logic      bus_ready;
	logic      bus_we;
	bus_addr_t bus_addr;
	bus_word_t bus_wdata;
	logic      bus_rsp_valid;
	logic      bus_rsp_ready;
	bus_word_t bus_rdata;

	// Model copies of the DUT state
	io_vec_t     m_data;
	io_vec_t     m_oeb;
	logic [2:0]  m_ctrl;
	logic        m_irq;
	logic        m_ext;

	logic [31:0] stim_lfsr = 32'd32670;
	logic [31:0] rdy_lfsr = 32'd32670;
	logic        spi_busy;
	logic        cmp_en;
	// SPI pins come from the SoC data register instead of the pads
	logic        via_soc;
	int          n_checks;
	int          n_errors;

	mgmt_io_top UUT (
		.clk_i           (clk),
		.rst_n_i         (rst_n),
		.pad_in_i        (pad_in),
		.pad_out_o       (pad_out),
		.pad_oeb_o       (pad_oeb),
		.mask_rev_i      (mask_rev),
		.irq_o           (irq),
		.ext_reset_o     (ext_reset),
		.bus_valid_i     (bus_valid),
		.bus_ready_o     (bus_ready),
		.bus_we_i        (bus_we),
		.bus_addr_i      (bus_addr),
		.bus_wdata_i     (bus_wdata),
		.bus_rsp_valid_o (bus_rsp_valid),
		.bus_rsp_ready_i (bus_rsp_ready),
		.bus_rdata_o     (bus_rdata)
	);

	always #2 clk = ~clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] r);
		r = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			r = {r[30:0], stim_lfsr[0]};
		end
	endtask

	// Random response back-pressure with one LFSR bit per cycle
	always @(posedge clk) begin
		rdy_lfsr = lfsr_next(rdy_lfsr);
		bus_rsp_ready <= rdy_lfsr[0];
	end

	// Expected {pad_out, pad_oeb} from the pad rules
	function automatic logic [2*`MGMT_IO_PADS-1:0] ref_pads(input io_vec_t data,
			input io_vec_t oeb, input logic [2:0] ctrl, input io_vec_t pin, input logic pass);
		io_vec_t o;
		io_vec_t e;
		io_vec_t src;
		o = data;
		e = oeb;
		src = ctrl[`CTRL_HK_CONNECT] ? data : pin;
		o[`PAD_JTAG] = ctrl[`CTRL_JTAG_OVR] ? data[`PAD_JTAG] : 1'b0;
		if (ctrl[`CTRL_SDO_OVR]) begin
			o[`PAD_SDO] = data[`PAD_SDO];
			e[`PAD_SDO] = oeb[`PAD_SDO];
		end else begin
			// Idle slave keeps SDO off while pass-through relays the flash reply
			o[`PAD_SDO] = pass ? pin[`PAD_UFL_IO1] : 1'b0;
			e[`PAD_SDO] = !pass;
		end
		if (pass) begin
			o[`PAD_UFL_CSB] = src[`PAD_CSB];
			o[`PAD_UFL_SCK] = src[`PAD_SCK];
			o[`PAD_UFL_IO0] = src[`PAD_SDI];
		end
		return {o, e};
	endfunction

	function automatic bus_word_t exp_reg(input bus_addr_t addr);
		case (addr)
			2'(`BUS_ADDR_DATA): return bus_word_t'(m_data);
			2'(`BUS_ADDR_OEB):  return bus_word_t'(m_oeb);
			2'(`BUS_ADDR_CTRL): return bus_word_t'(m_ctrl);
			default:            return '0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		n_checks++;
		assert (got === want) else begin
			n_errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_pads(input logic pass);
		logic [2*`MGMT_IO_PADS-1:0] want;
		want = ref_pads(m_data, m_oeb, m_ctrl, pad_in, pass);
		check_value("pad_out_o", 32'(pad_out), 32'(want[2*`MGMT_IO_PADS-1:`MGMT_IO_PADS]));
		check_value("pad_oeb_o", 32'(pad_oeb), 32'(want[`MGMT_IO_PADS-1:0]));
		check_value("irq_o", 32'(irq), 32'(m_irq));
		check_value("ext_reset_o", 32'(ext_reset), 32'(m_ext));
	endtask

	// A pending response stays valid and lets a request in only when it is taken
	task automatic expect_rsp_pending();
		check_value("bus_rsp_valid_o", 32'(bus_rsp_valid), 32'h1);
		check_value("bus_ready_o", 32'(bus_ready), 32'(bus_rsp_ready));
	endtask

	// Pad checker runs while no SPI transfer is in progress
	always @(negedge clk) begin
		if (cmp_en && !spi_busy) begin
			check_pads(1'b0);
		end
	end

	// One request that returns at the negedge before its response is taken
	task automatic bus_access(input logic we, input bus_addr_t addr, input bus_word_t wdata,
			output bus_word_t rdata);
		@(posedge clk);
		bus_valid <= 1'b1;
		bus_we    <= we;
		bus_addr  <= addr;
		bus_wdata <= wdata;
		@(negedge clk);
		while (!bus_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		bus_valid <= 1'b0;
		// Accepted on this edge
		if (we) begin
			case (addr)
				2'(`BUS_ADDR_DATA): m_data = io_vec_t'(wdata);
				2'(`BUS_ADDR_OEB):  m_oeb = io_vec_t'(wdata);
				2'(`BUS_ADDR_CTRL): m_ctrl = wdata[2:0];
				default: begin
				end
			endcase
		end
		// Response one cycle later and held until taken
		@(negedge clk);
		expect_rsp_pending();
		while (!bus_rsp_ready) begin
			@(negedge clk);
			expect_rsp_pending();
		end
		rdata = bus_rdata;
	endtask

	task automatic bus_check(input logic we, input bus_addr_t addr, input bus_word_t wdata);
		bus_word_t rdata;
		bus_access(we, addr, wdata, rdata);
		check_value("bus_rdata_o", rdata, exp_reg(addr));
	endtask

	// Drive the SPI pins, then hold them for a half period
	task automatic set_pins(input logic csb, input logic sck, input logic sdi);
		io_vec_t     nd;
		logic [31:0] r;
		if (via_soc) begin
			nd = m_data;
			nd[`PAD_CSB] = csb;
			nd[`PAD_SCK] = sck;
			nd[`PAD_SDI] = sdi;
			take_bits(3, r);
			// Noise on the pads, which the slave must not see
			@(posedge clk);
			pad_in[`PAD_SDI] <= r[0];
			pad_in[`PAD_CSB] <= r[1];
			pad_in[`PAD_SCK] <= r[2];
			bus_check(1'b1, 2'(`BUS_ADDR_DATA), bus_word_t'(nd));
		end else begin
			@(posedge clk);
			pad_in[`PAD_CSB] <= csb;
			pad_in[`PAD_SCK] <= sck;
			pad_in[`PAD_SDI] <= sdi;
		end
		repeat (HALF - 1) @(posedge clk);
	endtask

	task automatic spi_begin();
		spi_busy = 1'b1;
		set_pins(1'b0, 1'b0, 1'b0);
	endtask

	// Mode 0 byte sent MSB first with SDO sampled just before each rise
	task automatic spi_byte(input hk_byte_t b, output hk_byte_t rx);
		rx = '0;
		for (int i = 7; i >= 0; i--) begin
			set_pins(1'b0, 1'b0, b[i]);
			@(negedge clk);
			rx = {rx[6:0], pad_out[`PAD_SDO]};
			set_pins(1'b0, 1'b1, b[i]);
		end
	endtask

	task automatic spi_end();
		set_pins(1'b0, 1'b0, 1'b0);
		set_pins(1'b1, 1'b0, 1'b0);
		if (via_soc) begin
			@(posedge clk);
			pad_in[`PAD_CSB] <= 1'b1;
			pad_in[`PAD_SCK] <= 1'b0;
			pad_in[`PAD_SDI] <= 1'b0;
		end
		repeat (8) @(posedge clk);
		spi_busy = 1'b0;
	endtask

	task automatic spi_xfer(input hk_byte_t cmd, input hk_byte_t data, output hk_byte_t rx);
		hk_byte_t dummy;
		spi_begin();
		spi_byte(cmd, dummy);
		spi_byte(data, rx);
		// Housekeeping writes have bit 7 set
		if (cmd[7] && cmd[6:0] == 7'(`HK_ADDR_IRQ)) begin
			m_irq = data[0];
		end
		if (cmd[7] && cmd[6:0] == 7'(`HK_ADDR_RESET)) begin
			m_ext = data[0];
		end
		spi_end();
	endtask

	initial begin
		repeat (TIMEOUT) @(posedge clk);
		$display("Timeout after %0d cycles, the test sequence did not finish", TIMEOUT);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		bus_word_t   wdata;
		hk_byte_t    rx;
		hk_byte_t    dummy;
		io_vec_t     nd;
		clk = 1'b0;
		rst_n = 1'b0;
		pad_in = '0;
		pad_in[`PAD_CSB] = 1'b1;
		mask_rev = 8'hA5;
		bus_valid = 1'b0;
		bus_we = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		bus_rsp_ready = 1'b0;
		m_data = '0;
		m_oeb = '1;
		m_ctrl = '0;
		m_irq = 1'b0;
		m_ext = 1'b0;
		spi_busy = 1'b0;
		cmp_en = 1'b0;
		via_soc = 1'b0;
		n_checks = 0;
		n_errors = 0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		cmp_en = 1'b1;

		// Reset values
		bus_check(1'b0, 2'(`BUS_ADDR_DATA), '0);
		bus_check(1'b0, 2'(`BUS_ADDR_OEB), '0);
		bus_check(1'b0, 2'(`BUS_ADDR_CTRL), '0);
		bus_check(1'b0, 2'd3, '0);
		check_value("pad_oeb_o", 32'(pad_oeb), 32'({`MGMT_IO_PADS{1'b1}}));

		// Random traffic with hk_connect kept clear so the slave stays idle
		for (int k = 0; k < N_RAND; k++) begin
			take_bits(3, r);
			take_bits(32, wdata);
			if (r[2:1] == 2'(`BUS_ADDR_CTRL)) begin
				wdata[`CTRL_HK_CONNECT] = 1'b0;
			end
			bus_check(r[0], r[2:1], wdata);
		end

		// Housekeeping reads and writes from the pads
		bus_check(1'b1, 2'(`BUS_ADDR_CTRL), '0);
		spi_xfer(8'(`HK_ADDR_MASKREV), 8'h00, rx);
		check_value("spi mask_rev", 32'(rx), 32'(mask_rev));
		spi_xfer(8'h80 | 8'(`HK_ADDR_IRQ), 8'h01, rx);
		spi_xfer(8'h80 | 8'(`HK_ADDR_RESET), 8'h01, rx);
		spi_xfer(8'(`HK_ADDR_IRQ), 8'h00, rx);
		check_value("spi irq", 32'(rx), 32'(m_irq));
		spi_xfer(8'(`HK_ADDR_RESET), 8'h00, rx);
		check_value("spi ext_reset", 32'(rx), 32'(m_ext));
		spi_xfer(8'h80 | 8'(`HK_ADDR_IRQ), 8'h00, rx);
		spi_xfer(8'h80 | 8'(`HK_ADDR_RESET), 8'h00, rx);

		// SDO and JTAG overrides where pad 1 holds the SoC bit during a read
		bus_check(1'b1, 2'(`BUS_ADDR_DATA), 32'h5A03);
		bus_check(1'b1, 2'(`BUS_ADDR_OEB), 32'hFFFD);
		bus_check(1'b1, 2'(`BUS_ADDR_CTRL), 32'h3);
		spi_xfer(8'(`HK_ADDR_MASKREV), 8'h00, rx);
		check_value("pad 1 under sdo_ovr", 32'(rx), 32'({8{m_data[`PAD_SDO]}}));

		// Flash pass-through
		bus_check(1'b1, 2'(`BUS_ADDR_CTRL), '0);
		bus_check(1'b1, 2'(`BUS_ADDR_DATA), 32'h0500);
		spi_begin();
		spi_byte(`HK_CMD_PASSTHRU, dummy);
		for (int k = 0; k < 6; k++) begin
			take_bits(3, r);
			@(posedge clk);
			pad_in[`PAD_SCK] <= r[0];
			pad_in[`PAD_SDI] <= r[1];
			pad_in[`PAD_UFL_IO1] <= r[2];
			// Relay lags the pads by two cycles
			repeat (4) @(posedge clk);
			@(negedge clk);
			check_pads(1'b1);
		end
		spi_end();

		// SPI looped back from the SoC data register
		nd = m_data;
		nd[`PAD_CSB] = 1'b1;
		nd[`PAD_SCK] = 1'b0;
		nd[`PAD_SDI] = 1'b0;
		bus_check(1'b1, 2'(`BUS_ADDR_DATA), bus_word_t'(nd));
		bus_check(1'b1, 2'(`BUS_ADDR_CTRL), 32'(1 << `CTRL_HK_CONNECT));
		via_soc = 1'b1;
		spi_xfer(8'h80 | 8'(`HK_ADDR_IRQ), 8'h01, rx);
		via_soc = 1'b0;
		check_value("irq_o", 32'(irq), 32'h1);
		bus_check(1'b1, 2'(`BUS_ADDR_CTRL), '0);
		spi_xfer(8'h80 | 8'(`HK_ADDR_IRQ), 8'h00, rx);
		repeat (4) @(posedge clk);

		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: mgmt_io.f
+incdir+source
source/mgmt_io_pkg.sv
source/hk_spi_slave.sv
source/gpio_ctrl_regs.sv
source/pad_io_mux.sv
source/mgmt_io_top.sv
verif/mgmt_io_tb.sv

// File: Bender.yml
package:
  name: mgmt_io

export_include_dirs:
  - source

sources:
  - files:
      - source/mgmt_io_pkg.sv
      - source/hk_spi_slave.sv
      - source/gpio_ctrl_regs.sv
      - source/pad_io_mux.sv
      - source/mgmt_io_top.sv

  - target: simulation
    files:
      - verif/mgmt_io_tb.sv
